// File: dv/mask_alu_tb.sv
module mask_alu_tb import mask_alu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int LOGIC_ITERS  = 6;
  localparam int SCAN_ITERS   = 8;
  localparam int REDUCE_ITERS = 8;
  localparam int TOTAL_UOPS   = LOGIC_ITERS * 8 + SCAN_ITERS * 3 + REDUCE_ITERS * 2 + 5;
  localparam logic [4:0] SCAN_CODES [3]   = '{VS1_VMSBF, VS1_VMSIF, VS1_VMSOF};
  localparam logic [4:0] REDUCE_CODES [2] = '{VS1_VCPOP, VS1_VFIRST};

  logic                       clk;
  logic                       rst_n;
  logic                       uop_valid;
  logic [ROB_ENTRY_WIDTH-1:0] rob_entry;
  logic [5:0]                 uop_funct6;
  logic [2:0]                 uop_funct3;
  logic [4:0]                 vs1;
  logic                       vm;
  logic [VL_WIDTH-1:0]        vstart;
  logic [VL_WIDTH-1:0]        vl;
  logic [VLEN-1:0]            v0_data;
  logic                       v0_data_valid;
  logic [VLEN-1:0]            vd_data;
  logic                       vd_data_valid;
  logic [VLEN-1:0]            vs1_data;
  logic                       vs1_data_valid;
  logic [VLEN-1:0]            vs2_data;
  logic                       vs2_data_valid;
  logic                       rob_credit;
  logic                       uop_credit;
  logic                       result_valid;
  logic [ROB_ENTRY_WIDTH-1:0] result_rob_entry;
  mask_result_u               result_w_data;
  logic                       result_w_valid;
  logic                       result_ignore_vta;
  logic                       result_ignore_vma;

  // one scoreboard entry per issued uop in issue order
  string                      sb_name  [$];
  logic [ROB_ENTRY_WIDTH-1:0] sb_entry [$];
  logic [VLEN-1:0]            sb_data  [$];
  logic                       sb_wv    [$];
  logic                       sb_vta   [$];
  logic                       sb_vma   [$];

  logic [31:0]                rng_state = 32'h68260095;
  logic [ROB_ENTRY_WIDTH-1:0] next_tag = '0;
  int                         issue_credits = QUEUE_DEPTH;
  int                         rob_held = ROB_CREDITS;
  int                         rob_owed = 0;
  int                         cyc = 0;
  logic                       rst_q = 1'b0;

  tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mask_alu_top i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .uop_valid         (uop_valid),
    .rob_entry         (rob_entry),
    .uop_funct6        (uop_funct6),
    .uop_funct3        (uop_funct3),
    .vs1               (vs1),
    .vm                (vm),
    .vstart            (vstart),
    .vl                (vl),
    .v0_data           (v0_data),
    .v0_data_valid     (v0_data_valid),
    .vd_data           (vd_data),
    .vd_data_valid     (vd_data_valid),
    .vs1_data          (vs1_data),
    .vs1_data_valid    (vs1_data_valid),
    .vs2_data          (vs2_data),
    .vs2_data_valid    (vs2_data_valid),
    .rob_credit        (rob_credit),
    .uop_credit        (uop_credit),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_w_data     (result_w_data),
    .result_w_valid    (result_w_valid),
    .result_ignore_vta (result_ignore_vta),
    .result_ignore_vma (result_ignore_vma)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [VLEN-1:0] rand_mask();
    logic [VLEN-1:0] m;
    for (int w = 0; w < VLEN / 32; w++) begin
      m[32 * w +: 32] = rand32();
    end
    return m;
  endfunction

  task automatic check_field(input string test, input string field,
                             input logic [VLEN-1:0] exp, input logic [VLEN-1:0] act);
    assert (exp === act)
      else report_failure($sformatf("MISMATCH %s %s expected %h actual %h",
                                    test, field, exp, act));
  endtask

  // expected result of the uop now on the inputs
  task automatic predict_result(input string name);
    logic [VLEN-1:0] exp;
    logic            wv;
    logic            vta;
    logic            vma;
    logic            a;
    logic            b;
    logic            r;
    int              first;
    int              pop;
    exp   = '0;
    wv    = 1'b0;
    vta   = 1'b0;
    vma   = 1'b0;
    first = -1;
    pop   = 0;
    if (uop_funct3 == FUNCT3_OPMVV && uop_funct6[5:3] == 3'b011) begin
      wv  = vs1_data_valid && vs2_data_valid && vd_data_valid && vm;
      vta = 1'b1;
      for (int i = 0; i < VLEN; i++) begin
        a = vs2_data[i];
        b = vs1_data[i];
        case (uop_funct6)
          VMANDN:  r = a & ~b;
          VMAND:   r = a & b;
          VMOR:    r = a | b;
          VMXOR:   r = a ^ b;
          VMORN:   r = a | ~b;
          VMNAND:  r = ~(a & b);
          VMNOR:   r = ~(a | b);
          default: r = ~(a ^ b);
        endcase
        exp[i] = (i < int'(vstart)) ? vd_data[i] : r;
      end
    end else if (uop_funct3 == FUNCT3_OPMVV && uop_funct6 == VMUNARY0 &&
                 vs1 inside {VS1_VMSBF, VS1_VMSIF, VS1_VMSOF}) begin
      wv  = !vs1_data_valid && vs2_data_valid && (vm || (v0_data_valid && vd_data_valid));
      vta = 1'b1;
      vma = 1'b1;
      for (int i = 0; i < VLEN; i++) begin
        if (first < 0 && vs2_data[i] && i < int'(vl) && (vm || v0_data[i])) begin
          first = i;
        end
      end
      for (int i = 0; i < VLEN; i++) begin
        case (vs1)
          VS1_VMSBF: r = first < 0 || i < first;
          VS1_VMSIF: r = first < 0 || i <= first;
          default:   r = first < 0 || i == first;
        endcase
        exp[i] = (!vm && i < int'(vl) && !v0_data[i]) ? vd_data[i] : r;
      end
    end else if (uop_funct3 == FUNCT3_OPMVV && uop_funct6 == VWXUNARY0 &&
                 vs1 inside {VS1_VCPOP, VS1_VFIRST}) begin
      wv = !vs1_data_valid && vs2_data_valid && (vm || v0_data_valid);
      for (int i = 0; i < VLEN; i++) begin
        if (vs2_data[i] && i < int'(vl) && (vm || v0_data[i])) begin
          pop++;
          if (first < 0) begin
            first = i;
          end
        end
      end
      if (vs1 == VS1_VCPOP) begin
        exp = VLEN'(pop);
      end else if (first < 0) begin
        exp = {{(VLEN - XLEN){1'b0}}, {XLEN{1'b1}}};
      end else begin
        exp = VLEN'(first);
      end
    end
    if (!wv) begin
      exp = '0;
    end
    sb_name.push_back(name);
    sb_entry.push_back(rob_entry);
    sb_data.push_back(exp);
    sb_wv.push_back(wv);
    sb_vta.push_back(vta);
    sb_vma.push_back(vma);
  endtask

  // checks outputs and models the ROB on each falling edge
  task automatic advance_cycle();
    logic [31:0] gap;
    @(negedge clk);
    uop_valid = 1'b0;
    assert (uop_credit === result_valid)
      else report_failure("uop_credit pulse does not line up with result_valid");
    if (result_valid === 1'b1) begin
      assert (rob_held > 0)
        else report_failure("result_valid fired without a held ROB credit");
      assert (sb_entry.size() > 0)
        else report_failure("result came back with no uop outstanding");
      check_field(sb_name[0], "rob_entry", VLEN'(sb_entry[0]), VLEN'(result_rob_entry));
      check_field(sb_name[0], "w_valid", VLEN'(sb_wv[0]), VLEN'(result_w_valid));
      check_field(sb_name[0], "w_data", sb_data[0], result_w_data.mask);
      check_field(sb_name[0], "ignore_vta", VLEN'(sb_vta[0]), VLEN'(result_ignore_vta));
      check_field(sb_name[0], "ignore_vma", VLEN'(sb_vma[0]), VLEN'(result_ignore_vma));
      void'(sb_name.pop_front());
      void'(sb_entry.pop_front());
      void'(sb_data.pop_front());
      void'(sb_wv.pop_front());
      void'(sb_vta.pop_front());
      void'(sb_vma.pop_front());
      rob_held--;
      rob_owed++;
      issue_credits++;
    end
    // credits go back to the DUT with random gaps
    gap = rand32();
    rob_credit = 1'b0;
    if (rob_owed > 0 && gap[1:0] == 2'b00) begin
      rob_credit = 1'b1;
      rob_owed--;
      rob_held++;
    end
  endtask

  task automatic load_uop(input logic [5:0] f6, input logic [2:0] f3, input logic [4:0] s1,
                          input logic m, input logic s1_valid);
    uop_funct6     = f6;
    uop_funct3     = f3;
    vs1            = s1;
    vm             = m;
    vstart         = VL_WIDTH'(rand32() % (VLEN + 1));
    vl             = VL_WIDTH'(rand32() % (VLEN + 1));
    v0_data        = rand_mask();
    vd_data        = rand_mask();
    vs1_data       = rand_mask();
    vs2_data       = rand_mask();
    v0_data_valid  = 1'b1;
    vd_data_valid  = 1'b1;
    vs1_data_valid = s1_valid;
    vs2_data_valid = 1'b1;
  endtask

  task automatic issue_uop(input string name);
    while (issue_credits == 0) begin
      advance_cycle();
    end
    rob_entry = next_tag;
    uop_valid = 1'b1;
    predict_result(name);
    next_tag = next_tag + ROB_ENTRY_WIDTH'(1);
    issue_credits--;
    advance_cycle();
  endtask

  always @(posedge clk) begin
    cyc   <= cyc + 1;
    rst_q <= rst_n;
  end

  // covers every reset cycle and the first one after it
  assert property (@(posedge clk) disable iff (cyc < 2)
                   !rst_q |-> (!result_valid && !uop_credit))
    else report_failure("result_valid or uop_credit high during or right after reset");

  initial begin
    repeat (RESET_CYCLES + TOTAL_UOPS * 100) @(posedge clk);
    report_failure("watchdog timeout with results still outstanding");
  end

  initial begin
    uop_valid  = 1'b0;
    rob_credit = 1'b0;
    rob_entry  = '0;
    load_uop(6'd0, 3'd0, 5'd0, 1'b1, 1'b0);
    repeat (RESET_CYCLES + 2) advance_cycle();

    for (int it = 0; it < LOGIC_ITERS; it++) begin
      for (int k = 0; k < 8; k++) begin
        load_uop(VMANDN | 6'(k), FUNCT3_OPMVV, 5'(rand32()), 1'b1, 1'b1);
        issue_uop("mask_logical");
      end
    end
    for (int it = 0; it < SCAN_ITERS; it++) begin
      for (int k = 0; k < 3; k++) begin
        load_uop(VMUNARY0, FUNCT3_OPMVV, SCAN_CODES[k], 1'(it % 2), 1'b0);
        // empty source first and later a source with its low bits cleared
        vs2_data = (it < 2) ? '0 : rand_mask() << (rand32() % VLEN);
        issue_uop("mask_scan");
      end
    end
    for (int it = 0; it < REDUCE_ITERS; it++) begin
      for (int k = 0; k < 2; k++) begin
        load_uop(VWXUNARY0, FUNCT3_OPMVV, REDUCE_CODES[k], 1'(it % 2), 1'b0);
        vs2_data = (it < 2) ? '0 : rand_mask() << (rand32() % VLEN);
        issue_uop("mask_reduce");
      end
    end

    load_uop(VMAND, FUNCT3_OPMVV, 5'd0, 1'b1, 1'b1);
    vs2_data_valid = 1'b0;
    issue_uop("missing_vs2");
    load_uop(VMOR, FUNCT3_OPMVV, 5'd0, 1'b0, 1'b1);
    issue_uop("logic_vm_low");
    load_uop(VMAND, 3'b000, 5'd0, 1'b1, 1'b1);
    issue_uop("opivv_funct3");
    load_uop(VMUNARY0, FUNCT3_OPMVV, 5'b10000, 1'b1, 1'b0);
    issue_uop("unsupported_vs1");
    load_uop(VWXUNARY0, FUNCT3_OPMVV, VS1_VCPOP, 1'b1, 1'b1);
    issue_uop("reduce_vs1_valid");

    while (sb_entry.size() != 0 || issue_credits != QUEUE_DEPTH) begin
      advance_cycle();
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: mask_alu_top.f
rtl/mask_alu_pkg.sv
rtl/mask_uop_decode.sv
rtl/mask_logic_unit.sv
rtl/mask_scan_unit.sv
rtl/mask_reduce_unit.sv
rtl/mask_writeback_queue.sv
rtl/mask_alu_top.sv
dv/tb_clock_gen.sv
dv/mask_alu_tb.sv

// File: rtl/mask_alu_pkg.sv
package mask_alu_pkg;

  localparam int VLEN            = 128;
  localparam int XLEN            = 32;
  localparam int VL_WIDTH        = $clog2(VLEN) + 1;
  localparam int ROB_ENTRY_WIDTH = 4;
  localparam int QUEUE_DEPTH     = 2;
  localparam int ROB_CREDITS     = 2;

  localparam logic [2:0] FUNCT3_OPMVV = 3'b010;

  // mask-logical funct6, low three bits follow the sub-op order below
  localparam logic [5:0] VMANDN    = 6'b011000;
  localparam logic [5:0] VMAND     = 6'b011001;
  localparam logic [5:0] VMOR      = 6'b011010;
  localparam logic [5:0] VMXOR     = 6'b011011;
  localparam logic [5:0] VMORN     = 6'b011100;
  localparam logic [5:0] VMNAND    = 6'b011101;
  localparam logic [5:0] VMNOR     = 6'b011110;
  localparam logic [5:0] VMXNOR    = 6'b011111;
  localparam logic [5:0] VWXUNARY0 = 6'b010000;
  localparam logic [5:0] VMUNARY0  = 6'b010100;

  localparam logic [4:0] VS1_VCPOP  = 5'b10000;
  localparam logic [4:0] VS1_VFIRST = 5'b10001;
  localparam logic [4:0] VS1_VMSBF  = 5'b00001;
  localparam logic [4:0] VS1_VMSOF  = 5'b00010;
  localparam logic [4:0] VS1_VMSIF  = 5'b00011;

  typedef enum logic [1:0] {
    UNIT_NONE,
    UNIT_LOGIC,
    UNIT_SCAN,
    UNIT_REDUCE
  } mask_unit_e;

  typedef enum logic [2:0] {
    SUB_ANDN,
    SUB_AND,
    SUB_OR,
    SUB_XOR,
    SUB_ORN,
    SUB_NAND,
    SUB_NOR,
    SUB_XNOR
  } mask_sub_op_e;

  // scan and reduce ops reuse the low codes, the unit tells them apart
  localparam mask_sub_op_e SUB_SBF   = SUB_ANDN;
  localparam mask_sub_op_e SUB_SIF   = SUB_AND;
  localparam mask_sub_op_e SUB_SOF   = SUB_OR;
  localparam mask_sub_op_e SUB_CPOP  = SUB_ANDN;
  localparam mask_sub_op_e SUB_FIRST = SUB_AND;

  typedef union packed {
    logic [VLEN-1:0] mask;
    struct packed {
      logic [VLEN-XLEN-1:0] zero;
      logic [XLEN-1:0]      scalar;
    } word;
  } mask_result_u;

endpackage

// File: rtl/mask_alu_top.sv
module mask_alu_top import mask_alu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uop_valid,
  input  logic [ROB_ENTRY_WIDTH-1:0] rob_entry,
  input  logic [5:0]                 uop_funct6,
  input  logic [2:0]                 uop_funct3,
  input  logic [4:0]                 vs1,
  input  logic                       vm,
  input  logic [VL_WIDTH-1:0]        vstart,
  input  logic [VL_WIDTH-1:0]        vl,
  input  logic [VLEN-1:0]            v0_data,
  input  logic                       v0_data_valid,
  input  logic [VLEN-1:0]            vd_data,
  input  logic                       vd_data_valid,
  input  logic [VLEN-1:0]            vs1_data,
  input  logic                       vs1_data_valid,
  input  logic [VLEN-1:0]            vs2_data,
  input  logic                       vs2_data_valid,
  input  logic                       rob_credit,
  output logic                       uop_credit,
  output logic                       result_valid,
  output logic [ROB_ENTRY_WIDTH-1:0] result_rob_entry,
  output mask_result_u               result_w_data,
  output logic                       result_w_valid,
  output logic                       result_ignore_vta,
  output logic                       result_ignore_vma
);

  mask_unit_e      unit_sel;
  mask_sub_op_e    sub_op;
  logic [VLEN-1:0] src1;
  logic [VLEN-1:0] src2;
  logic [VLEN-1:0] keep_mask;
  logic            w_valid;
  logic            ignore_vta;
  logic            ignore_vma;
  logic [VLEN-1:0] logic_result;
  logic [VLEN-1:0] scan_result;
  mask_result_u    reduce_result;

  mask_uop_decode i_decode (
    .uop_funct6     (uop_funct6),
    .uop_funct3     (uop_funct3),
    .vs1            (vs1),
    .vm             (vm),
    .vstart         (vstart),
    .vl             (vl),
    .v0_data        (v0_data),
    .v0_data_valid  (v0_data_valid),
    .vd_data_valid  (vd_data_valid),
    .vs1_data       (vs1_data),
    .vs1_data_valid (vs1_data_valid),
    .vs2_data       (vs2_data),
    .vs2_data_valid (vs2_data_valid),
    .unit_sel       (unit_sel),
    .sub_op         (sub_op),
    .src1           (src1),
    .src2           (src2),
    .keep_mask      (keep_mask),
    .w_valid        (w_valid),
    .ignore_vta     (ignore_vta),
    .ignore_vma     (ignore_vma)
  );

  mask_logic_unit i_logic (
    .sub_op (sub_op),
    .src1   (src1),
    .src2   (src2),
    .result (logic_result)
  );

  mask_scan_unit i_scan (
    .sub_op (sub_op),
    .src2   (src2),
    .result (scan_result)
  );

  mask_reduce_unit i_reduce (
    .sub_op (sub_op),
    .src2   (src2),
    .result (reduce_result)
  );

  mask_writeback_queue i_queue (
    .clk               (clk),
    .rst_n             (rst_n),
    .uop_valid         (uop_valid),
    .rob_entry         (rob_entry),
    .unit_sel          (unit_sel),
    .w_valid           (w_valid),
    .ignore_vta        (ignore_vta),
    .ignore_vma        (ignore_vma),
    .keep_mask         (keep_mask),
    .vd_data           (vd_data),
    .logic_result      (logic_result),
    .scan_result       (scan_result),
    .reduce_result     (reduce_result),
    .rob_credit        (rob_credit),
    .uop_credit        (uop_credit),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_w_data     (result_w_data),
    .result_w_valid    (result_w_valid),
    .result_ignore_vta (result_ignore_vta),
    .result_ignore_vma (result_ignore_vma)
  );

endmodule

// File: rtl/mask_logic_unit.sv
module mask_logic_unit import mask_alu_pkg::*; (
  input  mask_sub_op_e    sub_op,
  input  logic [VLEN-1:0] src1,
  input  logic [VLEN-1:0] src2,
  output logic [VLEN-1:0] result
);

  // vs2 op vs1, the n forms invert vs1
  always_comb begin
    case (sub_op)
      SUB_ANDN: result = src2 & ~src1;
      SUB_AND:  result = src2 & src1;
      SUB_OR:   result = src2 | src1;
      SUB_XOR:  result = src2 ^ src1;
      SUB_ORN:  result = src2 | ~src1;
      SUB_NAND: result = ~(src2 & src1);
      SUB_NOR:  result = ~(src2 | src1);
      SUB_XNOR: result = ~(src2 ^ src1);
      default:  result = '0;
    endcase
  end

endmodule

// File: rtl/mask_reduce_unit.sv
module mask_reduce_unit import mask_alu_pkg::*; (
  input  mask_sub_op_e    sub_op,
  input  logic [VLEN-1:0] src2,
  output mask_result_u    result
);

  logic [4:0]              part_sum [VLEN/16];
  logic [VL_WIDTH-1:0]     pop_count;
  logic [$clog2(VLEN)-1:0] first_idx;

  // popcount per 16-bit slice, then add the slices
  always_comb begin
    for (int g = 0; g < VLEN / 16; g++) begin
      part_sum[g] = '0;
      for (int b = 0; b < 16; b++) begin
        part_sum[g] = part_sum[g] + 5'(src2[16 * g + b]);
      end
    end
    pop_count = '0;
    for (int g = 0; g < VLEN / 16; g++) begin
      pop_count = pop_count + VL_WIDTH'(part_sum[g]);
    end
  end

  // scanning down leaves the lowest set index
  always_comb begin
    first_idx = '0;
    for (int i = VLEN - 1; i >= 0; i--) begin
      if (src2[i]) begin
        first_idx = i[$clog2(VLEN)-1:0];
      end
    end
  end

  always_comb begin
    result.mask = '0;
    case (sub_op)
      SUB_CPOP:  result.word.scalar = XLEN'(pop_count);
      SUB_FIRST: result.word.scalar = (src2 == '0) ? '1 : XLEN'(first_idx);
      default:   result.word.scalar = '0;
    endcase
  end

endmodule

// File: rtl/mask_scan_unit.sv
module mask_scan_unit import mask_alu_pkg::*; (
  input  mask_sub_op_e    sub_op,
  input  logic [VLEN-1:0] src2,
  output logic [VLEN-1:0] result
);

  logic [VLEN-1:0] first_one;
  logic [VLEN-1:0] below_first;
  logic            src_zero;

  // two's complement trick isolates the lowest set bit
  assign first_one   = src2 & (~src2 + 1'b1);
  assign below_first = first_one - 1'b1;
  assign src_zero    = src2 == '0;

  always_comb begin
    if (src_zero) begin
      result = '1;
    end else begin
      case (sub_op)
        SUB_SBF: result = below_first;
        SUB_SIF: result = below_first | first_one;
        SUB_SOF: result = first_one;
        default: result = '0;
      endcase
    end
  end

endmodule

// File: rtl/mask_uop_decode.sv
module mask_uop_decode import mask_alu_pkg::*; (
  input  logic [5:0]          uop_funct6,
  input  logic [2:0]          uop_funct3,
  input  logic [4:0]          vs1,
  input  logic                vm,
  input  logic [VL_WIDTH-1:0] vstart,
  input  logic [VL_WIDTH-1:0] vl,
  input  logic [VLEN-1:0]     v0_data,
  input  logic                v0_data_valid,
  input  logic                vd_data_valid,
  input  logic [VLEN-1:0]     vs1_data,
  input  logic                vs1_data_valid,
  input  logic [VLEN-1:0]     vs2_data,
  input  logic                vs2_data_valid,
  output mask_unit_e          unit_sel,
  output mask_sub_op_e        sub_op,
  output logic [VLEN-1:0]     src1,
  output logic [VLEN-1:0]     src2,
  output logic [VLEN-1:0]     keep_mask,
  output logic                w_valid,
  output logic                ignore_vta,
  output logic                ignore_vma
);

  logic [VLEN-1:0] tail_mask;
  logic [VLEN-1:0] prestart_mask;
  logic [VLEN-1:0] active_mask;

  for (genvar i = 0; i < VLEN; i++) begin : g_bit_masks
    assign tail_mask[i]     = i < vl;
    assign prestart_mask[i] = i < vstart;
  end

  // body elements, further limited by v0 when masked
  assign active_mask = vm ? tail_mask : (tail_mask & v0_data);

  always_comb begin
    unit_sel = UNIT_NONE;
    sub_op   = SUB_ANDN;
    if (uop_funct3 == FUNCT3_OPMVV) begin
      case (uop_funct6)
        VMANDN, VMAND, VMOR, VMXOR, VMORN, VMNAND, VMNOR, VMXNOR: begin
          unit_sel = UNIT_LOGIC;
          sub_op   = mask_sub_op_e'(uop_funct6[2:0]);
        end
        VWXUNARY0: begin
          case (vs1)
            VS1_VCPOP:  begin unit_sel = UNIT_REDUCE; sub_op = SUB_CPOP;  end
            VS1_VFIRST: begin unit_sel = UNIT_REDUCE; sub_op = SUB_FIRST; end
            default:    unit_sel = UNIT_NONE;
          endcase
        end
        VMUNARY0: begin
          case (vs1)
            VS1_VMSBF: begin unit_sel = UNIT_SCAN; sub_op = SUB_SBF; end
            VS1_VMSIF: begin unit_sel = UNIT_SCAN; sub_op = SUB_SIF; end
            VS1_VMSOF: begin unit_sel = UNIT_SCAN; sub_op = SUB_SOF; end
            default:   unit_sel = UNIT_NONE;
          endcase
        end
        default: unit_sel = UNIT_NONE;
      endcase
    end
  end

  always_comb begin
    src1      = '0;
    src2      = '0;
    keep_mask = '0;
    w_valid   = 1'b0;
    case (unit_sel)
      UNIT_LOGIC: begin
        src1      = vs1_data;
        src2      = vs2_data;
        keep_mask = prestart_mask;
        w_valid   = vs1_data_valid & vs2_data_valid & vd_data_valid & vm;
      end
      UNIT_SCAN: begin
        src2      = vs2_data & active_mask;
        // masked-off body bits take the old vd
        keep_mask = vm ? '0 : (tail_mask & ~v0_data);
        w_valid   = !vs1_data_valid & vs2_data_valid & (vm | (v0_data_valid & vd_data_valid));
      end
      UNIT_REDUCE: begin
        src2    = vs2_data & active_mask;
        w_valid = !vs1_data_valid & vs2_data_valid & (vm | v0_data_valid);
      end
      default: w_valid = 1'b0;
    endcase
  end

  assign ignore_vta = (unit_sel == UNIT_LOGIC) || (unit_sel == UNIT_SCAN);
  assign ignore_vma = unit_sel == UNIT_SCAN;

endmodule

// File: rtl/mask_writeback_queue.sv
module mask_writeback_queue import mask_alu_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uop_valid,
  input  logic [ROB_ENTRY_WIDTH-1:0] rob_entry,
  input  mask_unit_e                 unit_sel,
  input  logic                       w_valid,
  input  logic                       ignore_vta,
  input  logic                       ignore_vma,
  input  logic [VLEN-1:0]            keep_mask,
  input  logic [VLEN-1:0]            vd_data,
  input  logic [VLEN-1:0]            logic_result,
  input  logic [VLEN-1:0]            scan_result,
  input  mask_result_u               reduce_result,
  input  logic                       rob_credit,
  output logic                       uop_credit,
  output logic                       result_valid,
  output logic [ROB_ENTRY_WIDTH-1:0] result_rob_entry,
  output mask_result_u               result_w_data,
  output logic                       result_w_valid,
  output logic                       result_ignore_vta,
  output logic                       result_ignore_vma
);

  logic [VLEN-1:0]                   sel_data;
  mask_result_u                      wr_data;
  logic [ROB_ENTRY_WIDTH-1:0]        q_rob_entry [QUEUE_DEPTH];
  mask_result_u                      q_data      [QUEUE_DEPTH];
  logic                              q_w_valid   [QUEUE_DEPTH];
  logic                              q_vta       [QUEUE_DEPTH];
  logic                              q_vma       [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0]    wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0]    rd_ptr;
  logic [$clog2(QUEUE_DEPTH+1)-1:0]  count;
  logic [$clog2(ROB_CREDITS+1)-1:0]  rob_cnt;
  logic                              pop;

  always_comb begin
    case (unit_sel)
      UNIT_LOGIC:  sel_data = logic_result;
      UNIT_SCAN:   sel_data = scan_result;
      UNIT_REDUCE: sel_data = reduce_result.mask;
      default:     sel_data = '0;
    endcase
  end

  // kept bits come from the old vd, an invalid uop returns zero data
  assign wr_data.mask = w_valid ? ((sel_data & ~keep_mask) | (vd_data & keep_mask)) : '0;

  always_ff @(posedge clk) begin
    if (uop_valid) begin
      q_rob_entry[wr_ptr] <= rob_entry;
      q_data[wr_ptr]      <= wr_data;
      q_w_valid[wr_ptr]   <= w_valid;
      q_vta[wr_ptr]       <= ignore_vta;
      q_vma[wr_ptr]       <= ignore_vma;
    end
  end

  // head leaves whenever a ROB credit is held
  assign pop = (count != '0) && (rob_cnt != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      rob_cnt <= ($clog2(ROB_CREDITS+1))'(ROB_CREDITS);
    end else begin
      if (uop_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({uop_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({rob_credit, pop})
        2'b10:   rob_cnt <= rob_cnt + 1'b1;
        2'b01:   rob_cnt <= rob_cnt - 1'b1;
        default: rob_cnt <= rob_cnt;
      endcase
    end
  end

  assign result_valid      = pop;
  assign uop_credit        = pop;
  assign result_rob_entry  = q_rob_entry[rd_ptr];
  assign result_w_data     = q_data[rd_ptr];
  assign result_w_valid    = q_w_valid[rd_ptr];
  assign result_ignore_vta = q_vta[rd_ptr];
  assign result_ignore_vma = q_vma[rd_ptr];

endmodule

// File: run.sh
#!/bin/sh
# build and run the mask ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mask_alu_tb -f mask_alu_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vmask_alu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
